// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_udp_axi_bridge
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: axi_addr_issue.sv
`timescale 1ns/1ps

module axi_addr_issue (
    input  logic                            gmii_rx_clk,
    input  logic                            rstn,
    input  logic                            cmd_empty,
    input  udp_axi_pkg::cmd_hdr_t           cmd_head,
    input  logic                            ready,
    output logic                            cmd_pop,
    output logic                            valid,
    output logic [udp_axi_pkg::addr_w-1:0]  addr,
    output logic [udp_axi_pkg::len_w-1:0]   len,
    output logic [udp_axi_pkg::burst_w-1:0] burst,
    output logic [udp_axi_pkg::id_w-1:0]    id
);

    logic idle;

    assign idle = !valid && !cmd_pop;           // nothing popped or held

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            cmd_pop <= 1'b0;
            valid   <= 1'b0;
        end else begin
            cmd_pop <= idle && !cmd_empty;      // one-cycle pop strobe
            if (cmd_pop) begin
                valid <= 1'b1;                  // head captured this edge
            end else if (valid && ready) begin
                valid <= 1'b0;                  // released on handshake only
            end
        end
    end

    // head is still on the FIFO output during the pop cycle
    always_ff @(posedge gmii_rx_clk) begin
        if (cmd_pop) begin
            addr  <= cmd_head.f.addr;
            len   <= cmd_head.f.len;
            burst <= cmd_head.f.burst;
            id    <= cmd_head.f.id;
        end
    end

    a_addr_stable: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        valid && !ready |=> valid && $stable(addr))
        else $error("axi_addr_issue: addr or valid changed before handshake");

endmodule

// File: axi_wdata_issue.sv
`timescale 1ns/1ps

module axi_wdata_issue (
    input  logic                           gmii_rx_clk,
    input  logic                           rstn,
    input  logic                           wd_empty,
    input  logic [udp_axi_pkg::data_w-1:0] wd_word,
    input  logic                           wd_last,
    input  logic                           wready,
    input  logic                           bvalid,
    input  logic [udp_axi_pkg::resp_w-1:0] bresp,
    output logic                           wd_pop,
    output logic                           wvalid,
    output logic                           wlast,
    output logic [udp_axi_pkg::data_w-1:0] wdata,
    output logic                           bready,
    output logic                           wr_resp_err
);

    logic b_hs;

    // W runs straight off the FIFO head
    assign wvalid = !wd_empty;
    assign wdata  = wd_word;
    assign wlast  = wd_last;
    assign wd_pop = wvalid && wready;           // next beat shows a cycle later

    assign b_hs = bvalid && bready;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            bready <= 1'b0;
        end else begin
            bready <= 1'b1;                     // responses are always taken
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_resp_err <= 1'b0;
        end else if (b_hs && bresp != udp_axi_pkg::resp_okay) begin
            wr_resp_err <= 1'b1;                // sticky until reset
        end
    end

    // pop timing of the FIFO must keep a beat up until it is taken
    a_wvalid_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid)
        else $error("axi_wdata_issue: wvalid dropped without handshake");

endmodule

// File: files.f
udp_axi_pkg.sv
sync_fifo.sv
udp_cmd_ctrl.sv
axi_addr_issue.sv
axi_wdata_issue.sv
udp_axi_bridge.sv
tb_udp_axi_bridge.sv

// File: sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width = 32,
    parameter int depth = 16
) (
    input  logic             gmii_rx_clk,
    input  logic             rstn,
    input  logic             push,
    input  logic             pop,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout,
    output logic             empty,
    output logic             full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));
    assign dout  = mem[rd_ptr];                 // head shows while not empty

    always_ff @(posedge gmii_rx_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // overflow is not handled in the datapath, so it must never happen
    a_no_push_full: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        push |-> !full)
        else $error("sync_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        pop |-> !empty)
        else $error("sync_fifo: pop while empty");

endmodule

// File: tb_udp_axi_bridge.sv
`timescale 1ns/1ps

module tb_udp_axi_bridge;

    localparam int cycle_limit = 4000;          // longest test is a few hundred cycles

    logic        gmii_rx_clk;
    logic        rstn;
    logic        udp_rx_en;
    logic        udp_rx_done;
    logic [31:0] udp_rx_data;
    logic [31:0] m_awaddr, m_araddr, m_wdata;
    logic [7:0]  m_awlen, m_arlen;
    logic [1:0]  m_awburst, m_arburst, m_awid, m_arid;
    logic        m_awvalid, m_arvalid, m_wvalid, m_wlast, m_bready, wr_resp_err;
    logic [3:0]  m_wstrb;
    logic        m_awready = 1'b0;
    logic        m_arready = 1'b0;
    logic        m_wready  = 1'b0;
    logic        m_bvalid  = 1'b0;
    logic [1:0]  m_bresp   = 2'b00;
    logic [1:0]  m_bid     = 2'b00;

    // expected transfers, written by the stimulus, consumed on handshakes
    logic [31:0] exp_aw_addr [64];
    logic [11:0] exp_aw_attr [64];              // {len, burst, id}
    logic [31:0] exp_ar_addr [64];
    logic [11:0] exp_ar_attr [64];
    logic [31:0] exp_w_data [64];
    logic        exp_w_last [64];
    logic [1:0]  resp_plan [64];                // bresp per write burst
    logic [5:0]  aw_wr_idx, aw_rd_idx, ar_wr_idx, ar_rd_idx, w_wr_idx, w_rd_idx;
    logic [5:0]  b_owed, b_sent;
    logic        err_exp;
    logic        quiet;                         // reset window, no valid allowed
    logic        aw_hold;
    logic        w_random;
    logic [31:0] pkt [$];
    int          cycles = 0;
    int          errors = 0;
    int          test_no = 0;
    int          tests_failed = 0;
    int          errs_before = 0;

    udp_axi_bridge #(.cmd_depth(16), .data_depth(512)) dut_i (.*);

    initial begin
        gmii_rx_clk = 1'b0;
        forever #5 gmii_rx_clk = ~gmii_rx_clk;
    end

    always @(posedge gmii_rx_clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout after %0d cycles, transfers still outstanding", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // slave side, driven on the falling edge
    always @(negedge gmii_rx_clk) begin
        m_awready = !aw_hold && ($urandom_range(0, 3) != 0);
        m_arready = ($urandom_range(0, 3) != 0);
        m_wready  = w_random ? ($urandom_range(0, 1) == 0) : 1'b1;
        m_bvalid  = (b_sent != b_owed);         // one response per last beat
        m_bresp   = resp_plan[b_sent];
    end

    always @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            aw_rd_idx <= '0;
            ar_rd_idx <= '0;
            w_rd_idx  <= '0;
            b_owed    <= '0;
            b_sent    <= '0;
            err_exp   <= 1'b0;
        end else begin
            if (m_awvalid && m_awready) aw_rd_idx <= aw_rd_idx + 6'd1;
            if (m_arvalid && m_arready) ar_rd_idx <= ar_rd_idx + 6'd1;
            if (m_wvalid && m_wready) w_rd_idx <= w_rd_idx + 6'd1;
            if (m_wvalid && m_wready && m_wlast) b_owed <= b_owed + 6'd1;
            if (m_bvalid && m_bready) begin
                b_sent <= b_sent + 6'd1;
                if (m_bresp != 2'b00) err_exp <= 1'b1;  // sticky on any non-OKAY
            end
        end
    end

    a_reset_quiet: assert property (@(posedge gmii_rx_clk)
        quiet |-> !(m_awvalid || m_arvalid || m_wvalid || wr_resp_err))
        else begin
            $display("[ERROR] {m_awvalid,m_arvalid,m_wvalid,wr_resp_err} got %h expected 0",
                     $sampled({m_awvalid, m_arvalid, m_wvalid, wr_resp_err}));
            errors++;
        end

    a_bready_reset: assert property (@(posedge gmii_rx_clk)
        !rstn |-> !m_bready)
        else begin
            $display("[ERROR] m_bready got %h expected 0", $sampled(m_bready));
            errors++;
        end

    // one cycle after release bready must be up and stay up
    a_bready_up: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        $past(rstn) |-> m_bready)
        else begin
            $display("[ERROR] m_bready got %h expected 1", $sampled(m_bready));
            errors++;
        end

    a_wstrb_full: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        m_wvalid |-> m_wstrb == 4'hF)
        else begin
            $display("[ERROR] m_wstrb got %h expected f", $sampled(m_wstrb));
            errors++;
        end

    a_aw_expected: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        m_awvalid && m_awready |-> aw_rd_idx != aw_wr_idx)
        else begin
            $display("unexpected write address %h taken on AW", $sampled(m_awaddr));
            errors++;
        end

    a_aw_match: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        m_awvalid && m_awready && aw_rd_idx != aw_wr_idx
        |-> {m_awaddr, m_awlen, m_awburst, m_awid}
            == {exp_aw_addr[aw_rd_idx], exp_aw_attr[aw_rd_idx]})
        else begin
            $display("[ERROR] {m_awaddr,m_awlen,m_awburst,m_awid} got %h expected %h",
                     $sampled({m_awaddr, m_awlen, m_awburst, m_awid}),
                     {exp_aw_addr[$sampled(aw_rd_idx)], exp_aw_attr[$sampled(aw_rd_idx)]});
            errors++;
        end

    a_ar_expected: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        m_arvalid && m_arready |-> ar_rd_idx != ar_wr_idx)
        else begin
            $display("unexpected read address %h taken on AR", $sampled(m_araddr));
            errors++;
        end

    a_ar_match: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        m_arvalid && m_arready && ar_rd_idx != ar_wr_idx
        |-> {m_araddr, m_arlen, m_arburst, m_arid}
            == {exp_ar_addr[ar_rd_idx], exp_ar_attr[ar_rd_idx]})
        else begin
            $display("[ERROR] {m_araddr,m_arlen,m_arburst,m_arid} got %h expected %h",
                     $sampled({m_araddr, m_arlen, m_arburst, m_arid}),
                     {exp_ar_addr[$sampled(ar_rd_idx)], exp_ar_attr[$sampled(ar_rd_idx)]});
            errors++;
        end

    a_w_expected: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        m_wvalid && m_wready |-> w_rd_idx != w_wr_idx)
        else begin
            $display("unexpected data beat %h taken on W", $sampled(m_wdata));
            errors++;
        end

    a_w_match: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        m_wvalid && m_wready && w_rd_idx != w_wr_idx
        |-> {m_wlast, m_wdata} == {exp_w_last[w_rd_idx], exp_w_data[w_rd_idx]})
        else begin
            $display("[ERROR] {m_wlast,m_wdata} got %h expected %h",
                     $sampled({m_wlast, m_wdata}),
                     {exp_w_last[$sampled(w_rd_idx)], exp_w_data[$sampled(w_rd_idx)]});
            errors++;
        end

    a_resp_err: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        wr_resp_err == err_exp)
        else begin
            $display("[ERROR] wr_resp_err got %h expected %h",
                     $sampled(wr_resp_err), $sampled(err_exp));
            errors++;
        end

    // one header pair, field layout from the command word definition
    task automatic put_cmd(input logic wr, input logic [7:0] op, input logic [31:0] addr,
                           input logic [7:0] len, input logic [1:0] burst,
                           input logic [1:0] id);
        pkt.push_back({op, burst, id, 3'b000, wr, len, 8'h00});
        pkt.push_back(addr);
        if (op == 8'h00 && wr) begin
            exp_aw_addr[aw_wr_idx] = addr;
            exp_aw_attr[aw_wr_idx] = {len, burst, id};
            aw_wr_idx = aw_wr_idx + 6'd1;
        end else if (op == 8'h00) begin
            exp_ar_addr[ar_wr_idx] = addr;
            exp_ar_attr[ar_wr_idx] = {len, burst, id};
            ar_wr_idx = ar_wr_idx + 6'd1;
        end
    endtask

    task automatic put_data(input int n);
        logic [31:0] word;
        pkt.push_back(32'hFF00_0000);           // marker, not forwarded
        for (int k = 0; k < n; k++) begin
            word = $urandom();
            pkt.push_back(word);
            exp_w_data[w_wr_idx] = word;
            exp_w_last[w_wr_idx] = (k == n - 1);
            w_wr_idx = w_wr_idx + 6'd1;
        end
    endtask

    task automatic send_pkt();
        for (int i = 0; i < pkt.size(); i++) begin
            @(negedge gmii_rx_clk);
            udp_rx_en   = 1'b1;
            udp_rx_data = pkt[i];
            udp_rx_done = (i == pkt.size() - 1);
        end
        @(negedge gmii_rx_clk);
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        udp_rx_data = '0;
        pkt.delete();
        repeat (2) @(negedge gmii_rx_clk);
    endtask

    // the cycle counter bounds this loop
    task automatic wait_drained();
        while (aw_rd_idx != aw_wr_idx || ar_rd_idx != ar_wr_idx ||
               w_rd_idx != w_wr_idx || b_sent != b_owed) begin
            @(negedge gmii_rx_clk);
        end
        repeat (4) @(negedge gmii_rx_clk);
    endtask

    task automatic end_test(input string name);
        test_no++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_no, name, errors - errs_before);
            tests_failed++;
        end
        errs_before = errors;
    endtask

    initial begin
        void'($urandom(38167));
        rstn        = 1'b0;
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        udp_rx_data = '0;
        quiet       = 1'b1;
        aw_hold     = 1'b0;
        w_random    = 1'b0;
        aw_wr_idx   = '0;
        ar_wr_idx   = '0;
        w_wr_idx    = '0;
        for (int i = 0; i < 64; i++) begin
            resp_plan[i] = 2'b00;
        end
        repeat (3) @(posedge gmii_rx_clk);
        @(negedge gmii_rx_clk);
        rstn = 1'b1;
        repeat (3) @(negedge gmii_rx_clk);
        quiet = 1'b0;
        end_test("reset state");

        put_cmd(1'b1, 8'h00, 32'h4000_1000, 8'd3, 2'b01, 2'd1);
        send_pkt();
        wait_drained();
        end_test("write command");

        put_cmd(1'b0, 8'h00, 32'h8000_0040, 8'd7, 2'b01, 2'd2);
        put_cmd(1'b1, 8'h5A, 32'hDEAD_0000, 8'd0, 2'b01, 2'd3);   // must be dropped
        put_cmd(1'b1, 8'h00, 32'h4000_2000, 8'd1, 2'b10, 2'd0);
        send_pkt();
        wait_drained();
        end_test("read command and dropped pair");

        aw_hold  = 1'b1;                        // commands queue up behind AW
        w_random = 1'b1;
        put_cmd(1'b1, 8'h00, 32'h4000_3000, 8'd7, 2'b01, 2'd1);
        put_cmd(1'b1, 8'h00, 32'h4000_3100, 8'd0, 2'b00, 2'd2);
        put_cmd(1'b1, 8'h00, 32'h4000_3200, 8'd15, 2'b01, 2'd3);
        send_pkt();
        put_data(8);
        send_pkt();
        repeat (30) @(negedge gmii_rx_clk);
        aw_hold = 1'b0;
        wait_drained();
        end_test("data packet");

        resp_plan[b_owed]         = 2'b00;
        resp_plan[b_owed + 6'd1]  = 2'b10;      // SLVERR
        resp_plan[b_owed + 6'd2]  = 2'b00;
        put_data(2);
        send_pkt();
        put_data(3);
        send_pkt();
        put_data(2);
        send_pkt();
        wait_drained();
        end_test("write response");

        $display("tests run %0d, tests failed %0d, errors %0d", test_no, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: udp_axi_bridge.sv
`timescale 1ns/1ps

module udp_axi_bridge #(
    parameter int cmd_depth  = 16,
    parameter int data_depth = 512
) (
    input  logic                              gmii_rx_clk,
    input  logic                              rstn,
    input  logic                              udp_rx_en,
    input  logic                              udp_rx_done,
    input  logic [udp_axi_pkg::data_w-1:0]    udp_rx_data,
    output logic [udp_axi_pkg::addr_w-1:0]    m_awaddr,
    output logic [udp_axi_pkg::len_w-1:0]     m_awlen,
    output logic [udp_axi_pkg::burst_w-1:0]   m_awburst,
    output logic [udp_axi_pkg::id_w-1:0]      m_awid,
    output logic                              m_awvalid,
    input  logic                              m_awready,
    output logic [udp_axi_pkg::addr_w-1:0]    m_araddr,
    output logic [udp_axi_pkg::len_w-1:0]     m_arlen,
    output logic [udp_axi_pkg::burst_w-1:0]   m_arburst,
    output logic [udp_axi_pkg::id_w-1:0]      m_arid,
    output logic                              m_arvalid,
    input  logic                              m_arready,
    output logic [udp_axi_pkg::data_w-1:0]    m_wdata,
    output logic [udp_axi_pkg::data_w/8-1:0]  m_wstrb,
    output logic                              m_wlast,
    output logic                              m_wvalid,
    input  logic                              m_wready,
    input  logic [udp_axi_pkg::id_w-1:0]      m_bid,
    input  logic [udp_axi_pkg::resp_w-1:0]    m_bresp,
    input  logic                              m_bvalid,
    output logic                              m_bready,
    output logic                              wr_resp_err
);

    localparam int cmd_w = $bits(udp_axi_pkg::cmd_hdr_t);
    localparam int wd_w  = udp_axi_pkg::data_w + 1;     // word plus last tag

    logic                           aw_push, ar_push, aw_pop, ar_pop;
    logic                           aw_full, ar_full, aw_empty, ar_empty;
    udp_axi_pkg::cmd_hdr_t          aw_cmd, ar_cmd, aw_head, ar_head;
    logic                           wd_push, wd_pop, wd_full, wd_empty, wd_last;
    logic [udp_axi_pkg::data_w-1:0] wd_word;
    logic [wd_w-1:0]                wd_head;

    assign m_wstrb = '1;                        // full-word writes only

    udp_cmd_ctrl ctrl_i (
        .gmii_rx_clk, .rstn, .udp_rx_en, .udp_rx_done, .udp_rx_data,
        .aw_full, .ar_full, .wd_full,
        .aw_push, .ar_push, .aw_cmd, .ar_cmd,
        .wd_push, .wd_last, .wd_word
    );

    sync_fifo #(.width(cmd_w), .depth(cmd_depth)) aw_fifo_i (
        .gmii_rx_clk, .rstn, .push(aw_push), .pop(aw_pop), .din(aw_cmd),
        .dout(aw_head), .empty(aw_empty), .full(aw_full)
    );

    sync_fifo #(.width(cmd_w), .depth(cmd_depth)) ar_fifo_i (
        .gmii_rx_clk, .rstn, .push(ar_push), .pop(ar_pop), .din(ar_cmd),
        .dout(ar_head), .empty(ar_empty), .full(ar_full)
    );

    sync_fifo #(.width(wd_w), .depth(data_depth)) wd_fifo_i (
        .gmii_rx_clk, .rstn, .push(wd_push), .pop(wd_pop), .din({wd_last, wd_word}),
        .dout(wd_head), .empty(wd_empty), .full(wd_full)
    );

    axi_addr_issue aw_issue_i (
        .gmii_rx_clk, .rstn, .cmd_empty(aw_empty), .cmd_head(aw_head),
        .ready(m_awready), .cmd_pop(aw_pop), .valid(m_awvalid),
        .addr(m_awaddr), .len(m_awlen), .burst(m_awburst), .id(m_awid)
    );

    axi_addr_issue ar_issue_i (
        .gmii_rx_clk, .rstn, .cmd_empty(ar_empty), .cmd_head(ar_head),
        .ready(m_arready), .cmd_pop(ar_pop), .valid(m_arvalid),
        .addr(m_araddr), .len(m_arlen), .burst(m_arburst), .id(m_arid)
    );

    axi_wdata_issue w_issue_i (
        .gmii_rx_clk, .rstn,
        .wd_empty, .wd_word(wd_head[udp_axi_pkg::data_w-1:0]),
        .wd_last(wd_head[udp_axi_pkg::data_w]), .wready(m_wready),
        .bvalid(m_bvalid), .bresp(m_bresp),
        .wd_pop, .wvalid(m_wvalid), .wlast(m_wlast), .wdata(m_wdata),
        .bready(m_bready), .wr_resp_err
    );

    // slave must present a clean id and response with every B beat
    a_b_known: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        m_bvalid |-> !$isunknown({m_bid, m_bresp}))
        else $error("udp_axi_bridge: unknown bid/bresp on B channel");

endmodule

// File: udp_axi_pkg.sv
package udp_axi_pkg;

    parameter int data_w  = 32;                 // udp word and axi data
    parameter int addr_w  = 32;
    parameter int len_w   = 8;
    parameter int id_w    = 2;
    parameter int burst_w = 2;
    parameter int resp_w  = 2;

    parameter logic [7:0] op_cmd  = 8'h00;      // command packet / valid pair
    parameter logic [7:0] op_data = 8'hFF;      // data packet marker

    parameter logic [resp_w-1:0] resp_okay = 2'b00;

    // field layout of one header pair, high word first
    typedef struct packed {
        logic [7:0]         opcode;             // 00 marks a live command
        logic [burst_w-1:0] burst;
        logic [id_w-1:0]    id;
        logic [2:0]         rsv_hi;
        logic               wr;                 // 1 write, 0 read
        logic [len_w-1:0]   len;                // beats minus one
        logic [7:0]         rsv_lo;
        logic [addr_w-1:0]  addr;               // low word of the pair
    } cmd_fields_t;

    // same 64 bits seen as a plain word, as stored in the address FIFOs
    typedef union packed {
        logic [63:0] raw;
        cmd_fields_t f;
    } cmd_hdr_t;

endpackage

// File: udp_cmd_ctrl.sv
`timescale 1ns/1ps

module udp_cmd_ctrl (
    input  logic                           gmii_rx_clk,
    input  logic                           rstn,
    input  logic                           udp_rx_en,
    input  logic                           udp_rx_done,
    input  logic [udp_axi_pkg::data_w-1:0] udp_rx_data,
    input  logic                           aw_full,
    input  logic                           ar_full,
    input  logic                           wd_full,
    output logic                           aw_push,
    output logic                           ar_push,
    output udp_axi_pkg::cmd_hdr_t          aw_cmd,
    output udp_axi_pkg::cmd_hdr_t          ar_cmd,
    output logic                           wd_push,
    output logic                           wd_last,
    output logic [udp_axi_pkg::data_w-1:0] wd_word
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_cmd  = 2'd1;
    localparam logic [1:0] st_data = 2'd2;

    logic [1:0]                     state;
    logic                           sop;        // next word opens a packet
    logic                           lo_next;    // next word is an address word
    logic [udp_axi_pkg::data_w-1:0] hi_word;
    logic [7:0]                     top_byte;
    udp_axi_pkg::cmd_hdr_t          pair_hdr;
    udp_axi_pkg::cmd_hdr_t          cmd_q;

    assign top_byte = udp_rx_data[udp_axi_pkg::data_w-1 -: 8];

    always_comb begin
        pair_hdr.raw = {hi_word, udp_rx_data};  // held high word + current low
    end

    // one command register feeds both address FIFOs, the push picks the target
    assign aw_cmd = cmd_q;
    assign ar_cmd = cmd_q;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state   <= st_idle;
            sop     <= 1'b1;
            lo_next <= 1'b0;
            aw_push <= 1'b0;
            ar_push <= 1'b0;
            wd_push <= 1'b0;
        end else begin
            aw_push <= 1'b0;
            ar_push <= 1'b0;
            wd_push <= 1'b0;
            if (udp_rx_done) begin
                sop <= 1'b1;
            end else if (udp_rx_en) begin
                sop <= 1'b0;
            end
            case (state)
                st_idle: begin
                    // words after an unknown first byte are skipped until done
                    if (udp_rx_en && sop && !udp_rx_done) begin
                        if (top_byte == udp_axi_pkg::op_cmd) begin
                            state   <= st_cmd;
                            lo_next <= 1'b1;    // first word was the high word
                        end else if (top_byte == udp_axi_pkg::op_data) begin
                            state <= st_data;   // marker is not forwarded
                        end
                    end
                end
                st_cmd: begin
                    if (udp_rx_en) begin
                        lo_next <= !lo_next;
                        if (lo_next && pair_hdr.f.opcode == udp_axi_pkg::op_cmd) begin
                            aw_push <= pair_hdr.f.wr;
                            ar_push <= !pair_hdr.f.wr;
                        end
                    end
                    if (udp_rx_done) begin
                        state   <= st_idle;
                        lo_next <= 1'b0;        // odd trailing word is dropped
                    end
                end
                st_data: begin
                    wd_push <= udp_rx_en;
                    if (udp_rx_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (udp_rx_en && !lo_next) begin
            hi_word <= udp_rx_data;
        end
        if (udp_rx_en && lo_next) begin
            cmd_q <= pair_hdr;
        end
        if (udp_rx_en) begin
            wd_word <= udp_rx_data;
            wd_last <= udp_rx_done;             // packet end tags the last beat
        end
    end

    // the UDP side has no back-pressure, so a full FIFO here is a lost word
    a_push_not_full: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        !(aw_push && aw_full) && !(ar_push && ar_full) && !(wd_push && wd_full))
        else $error("udp_cmd_ctrl: push into a full FIFO");

endmodule
